/* Bender.yml */
package:
  name: exec_stage

sources:
  - src/exec_pkg.sv
  - src/exec_ctrl.sv
  - src/int_alu.sv
  - src/flag_unit.sv
  - src/branch_unit.sv
  - src/exec_stage.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/exec_sva.sv
      - verification/exec_tb.sv

/* list.f */
src/exec_pkg.sv
src/exec_ctrl.sv
src/int_alu.sv
src/flag_unit.sv
src/branch_unit.sv
src/exec_stage.sv
verification/tb_clock.sv
verification/exec_sva.sv
verification/exec_tb.sv

/* src/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit
	import exec_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            advance,
	input  logic            idle,
	input  logic [1:0]      br_kind,
	input  opcode_u         opcode,
	input  logic [XLEN-1:0] rflags,
	input  logic [XLEN-1:0] oprd1,
	input  logic [XLEN-1:0] next_rip,
	output logic            branch,
	output logic [XLEN-1:0] branch_rip
);
	logic            cond_ok;
	logic            taken;
	logic [XLEN-1:0] target;

	// Condition codes checked against flags from before this instruction.
	always_comb begin
		case (opcode.cond.cc)
			4'h0: cond_ok = rflags[RF_OF];
			4'h1: cond_ok = !rflags[RF_OF];
			4'h2: cond_ok = rflags[RF_CF];
			4'h3: cond_ok = !rflags[RF_CF];
			4'h4: cond_ok = rflags[RF_ZF];
			4'h5: cond_ok = !rflags[RF_ZF];
			4'h6: cond_ok = rflags[RF_ZF] || rflags[RF_CF];
			4'h7: cond_ok = !(rflags[RF_ZF] || rflags[RF_CF]);
			4'h8: cond_ok = rflags[RF_SF];
			4'h9: cond_ok = !rflags[RF_SF];
			4'hA: cond_ok = rflags[RF_PF];
			4'hB: cond_ok = !rflags[RF_PF];
			4'hC: cond_ok = (rflags[RF_SF] != rflags[RF_OF]);
			4'hD: cond_ok = (rflags[RF_SF] == rflags[RF_OF]);
			4'hE: cond_ok = rflags[RF_ZF] || (rflags[RF_SF] != rflags[RF_OF]);
			default: cond_ok = !rflags[RF_ZF] && (rflags[RF_SF] == rflags[RF_OF]);
		endcase
	end

	always_comb begin
		case (br_kind)
			BR_COND:       taken = cond_ok;
			BR_ALWAYS_REL: taken = 1'b1;
			BR_ALWAYS_ABS: taken = 1'b1;
			default:       taken = 1'b0;
		endcase
	end

	// Displacement arrives sign-extended in oprd1.
	assign target = (br_kind == BR_ALWAYS_ABS) ? oprd1 : next_rip + oprd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			branch     <= 1'b0;
			branch_rip <= '0;
		end else if (advance) begin
			branch     <= taken;
			branch_rip <= target;
		end else if (idle) begin
			branch <= 1'b0; // Target is left as it was.
		end
	end

endmodule

/* src/exec_ctrl.sv */
`timescale 1ns/1ns

module exec_ctrl
	import exec_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       enable,
	input  logic       mem_blocked,
	input  opcode_u    opcode,
	output logic       advance,
	output logic       idle,
	output logic [2:0] alu_op,
	output logic [1:0] flag_cls,
	output logic [1:0] br_kind,
	output logic       exe_mem,
	output logic       illegal
);
	logic ill_dec;

	assign advance = enable && !mem_blocked;
	assign idle    = !enable && !mem_blocked; // Bubble, outputs fall back.

	always_comb begin
		alu_op   = ALU_PASS2;
		flag_cls = FLAGS_NONE;
		br_kind  = BR_NONE;
		ill_dec  = 1'b0;
		casez ({opcode.plain.map, opcode.plain.op})
			10'b00_0000_0???: begin // ADD 0x00-0x07.
				alu_op   = ALU_ADD;
				flag_cls = FLAGS_ARITH;
			end
			10'b00_0000_1???: begin // OR 0x08-0x0F.
				alu_op   = ALU_OR;
				flag_cls = FLAGS_LOGIC;
			end
			10'b00_0010_0???: begin // AND 0x20-0x27.
				alu_op   = ALU_AND;
				flag_cls = FLAGS_LOGIC;
			end
			10'b00_0011_0???: begin // XOR 0x30-0x37.
				alu_op   = ALU_XOR;
				flag_cls = FLAGS_LOGIC;
			end
			10'b00_1000_10??, 10'b00_1011_1???, 10'b00_1100_0111: begin
				alu_op = ALU_PASS2; // MOV forms.
			end
			10'b00_1111_0111: begin // IMUL.
				alu_op   = ALU_MUL;
				flag_cls = FLAGS_MUL;
			end
			10'b00_0111_????, 10'b01_1000_????: begin
				br_kind = BR_COND; // Short and long Jcc.
			end
			10'b00_1110_1011: br_kind = BR_ALWAYS_REL; // JMP rel8.
			10'b00_1100_0011: begin // RET, target already popped upstream.
				alu_op  = ALU_PASS1;
				br_kind = BR_ALWAYS_ABS;
			end
			// Group extensions.
			10'b11_0000_0011: begin
				alu_op   = ALU_ADD;
				flag_cls = FLAGS_ARITH;
			end
			10'b11_0000_0001: begin
				alu_op   = ALU_OR;
				flag_cls = FLAGS_LOGIC;
			end
			10'b11_0000_0010: begin
				alu_op   = ALU_AND;
				flag_cls = FLAGS_LOGIC;
			end
			10'b11_0000_0100: begin
				alu_op   = ALU_XOR;
				flag_cls = FLAGS_LOGIC;
			end
			10'b11_0001_0000: begin // CALL 0xFF /2.
				alu_op  = ALU_RIP;
				br_kind = BR_ALWAYS_ABS;
			end
			default: ill_dec = 1'b1; // SYSCALL lands here too.
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exe_mem <= 1'b0;
			illegal <= 1'b0;
		end else if (advance) begin
			exe_mem <= 1'b1;
			illegal <= ill_dec;
		end else if (idle) begin
			exe_mem <= 1'b0;
			illegal <= 1'b0;
		end
	end

endmodule

/* src/exec_pkg.sv */
package exec_pkg;

	localparam int XLEN = 64;

	// One decoded opcode word, read either as map plus byte or with the
	// condition nibble split out for Jcc.
	typedef union packed {
		struct packed {
			logic [1:0] map;      // 0 one-byte, 1 0x0F map, 3 group ext.
			logic [7:0] op;
		} plain;
		struct packed {
			logic [1:0] map;
			logic [3:0] row;
			logic [3:0] cc;       // x86 condition code.
		} cond;
	} opcode_u;

	// RFLAGS bit positions.
	localparam int RF_CF = 0;
	localparam int RF_PF = 2;
	localparam int RF_ZF = 6;
	localparam int RF_SF = 7;
	localparam int RF_OF = 11;

	// ALU operation selects.
	localparam logic [2:0] ALU_ADD   = 3'd0;
	localparam logic [2:0] ALU_OR    = 3'd1;
	localparam logic [2:0] ALU_XOR   = 3'd2;
	localparam logic [2:0] ALU_AND   = 3'd3;
	localparam logic [2:0] ALU_PASS2 = 3'd4;
	localparam logic [2:0] ALU_PASS1 = 3'd5;
	localparam logic [2:0] ALU_MUL   = 3'd6;
	localparam logic [2:0] ALU_RIP   = 3'd7; // Return address for CALL.

	// Branch kinds.
	localparam logic [1:0] BR_NONE       = 2'd0;
	localparam logic [1:0] BR_COND       = 2'd1;
	localparam logic [1:0] BR_ALWAYS_REL = 2'd2;
	localparam logic [1:0] BR_ALWAYS_ABS = 2'd3;

	// Flag update classes.
	localparam logic [1:0] FLAGS_NONE  = 2'd0;
	localparam logic [1:0] FLAGS_ARITH = 2'd1;
	localparam logic [1:0] FLAGS_LOGIC = 2'd2;
	localparam logic [1:0] FLAGS_MUL   = 2'd3;

endpackage

/* src/exec_stage.sv */
`timescale 1ns/1ns

module exec_stage
	import exec_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              enable,
	input  opcode_u           opcode,
	input  logic [XLEN-1:0]   oprd1,
	input  logic [XLEN-1:0]   oprd2,
	input  logic [XLEN-1:0]   oprd3,    // Kept for the core interface only.
	input  logic [XLEN-1:0]   next_rip,
	input  logic              mem_blocked,
	output logic [2*XLEN-1:0] result,
	output logic [XLEN-1:0]   rflags,
	output logic              exe_mem,
	output logic              illegal,
	output logic              branch,
	output logic [XLEN-1:0]   branch_rip
);
	logic              advance;
	logic              idle;
	logic [2:0]        alu_op;
	logic [1:0]        flag_cls;
	logic [1:0]        br_kind;
	logic [2*XLEN-1:0] sum_wide;
	logic              carry;

	exec_ctrl exec_ctrl_inst (
		.clk, .rst, .enable, .mem_blocked, .opcode,
		.advance, .idle, .alu_op, .flag_cls, .br_kind,
		.exe_mem, .illegal
	);

	int_alu int_alu_inst (
		.clk, .rst, .advance, .idle, .alu_op,
		.oprd1, .oprd2, .next_rip,
		.result, .sum_wide, .carry
	);

	flag_unit flag_unit_inst (
		.clk, .rst, .advance, .flag_cls,
		.oprd1, .oprd2, .sum_wide, .carry,
		.rflags
	);

	branch_unit branch_unit_inst (
		.clk, .rst, .advance, .idle, .br_kind, .opcode,
		.rflags, .oprd1, .next_rip,
		.branch, .branch_rip
	);

endmodule

/* src/flag_unit.sv */
`timescale 1ns/1ns

module flag_unit
	import exec_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              advance,
	input  logic [1:0]        flag_cls,
	input  logic [XLEN-1:0]   oprd1,
	input  logic [XLEN-1:0]   oprd2,
	input  logic [2*XLEN-1:0] sum_wide,
	input  logic              carry,
	output logic [XLEN-1:0]   rflags
);
	logic            zf;
	logic            sf;
	logic            pf;
	logic            add_ovf;
	logic            mul_ovf;
	logic [XLEN-1:0] rflags_next;

	assign zf = (sum_wide[XLEN-1:0] == '0);
	assign sf = sum_wide[XLEN-1];
	assign pf = ~^sum_wide[7:0]; // Set on even parity of the low byte.

	// Same operand signs, different result sign.
	assign add_ovf = (oprd1[XLEN-1] == oprd2[XLEN-1]) &&
		(sum_wide[XLEN-1] != oprd1[XLEN-1]);

	// Upper half must be pure sign extension of the lower half.
	assign mul_ovf = (sum_wide[2*XLEN-1:XLEN] != {XLEN{sum_wide[XLEN-1]}});

	always_comb begin
		rflags_next = rflags;
		if (flag_cls != FLAGS_NONE) begin
			rflags_next[RF_ZF] = zf;
			rflags_next[RF_SF] = sf;
			rflags_next[RF_PF] = pf;
		end
		case (flag_cls)
			FLAGS_ARITH: begin
				rflags_next[RF_CF] = carry;
				rflags_next[RF_OF] = add_ovf;
			end
			FLAGS_LOGIC: begin
				rflags_next[RF_CF] = 1'b0;
				rflags_next[RF_OF] = 1'b0;
			end
			FLAGS_MUL: begin
				rflags_next[RF_CF] = mul_ovf;
				rflags_next[RF_OF] = mul_ovf;
			end
			default: ; // Flags untouched.
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rflags <= '0;
		end else if (advance) begin
			rflags <= rflags_next;
		end
	end

endmodule

/* src/int_alu.sv */
`timescale 1ns/1ns

module int_alu
	import exec_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              advance,
	input  logic              idle,
	input  logic [2:0]        alu_op,
	input  logic [XLEN-1:0]   oprd1,
	input  logic [XLEN-1:0]   oprd2,
	input  logic [XLEN-1:0]   next_rip,
	output logic [2*XLEN-1:0] result,
	output logic [2*XLEN-1:0] sum_wide,
	output logic              carry
);
	logic [XLEN:0]          add_full;
	logic signed [2*XLEN-1:0] prod;

	assign add_full = {1'b0, oprd1} + {1'b0, oprd2};
	assign carry    = add_full[XLEN];
	assign prod     = $signed(oprd1) * $signed(oprd2); // Full signed product.

	always_comb begin
		case (alu_op)
			ALU_ADD:   sum_wide = {{XLEN{1'b0}}, add_full[XLEN-1:0]};
			ALU_OR:    sum_wide = {{XLEN{1'b0}}, oprd1 | oprd2};
			ALU_XOR:   sum_wide = {{XLEN{1'b0}}, oprd1 ^ oprd2};
			ALU_AND:   sum_wide = {{XLEN{1'b0}}, oprd1 & oprd2};
			ALU_PASS1: sum_wide = {{XLEN{1'b0}}, oprd1};
			ALU_MUL:   sum_wide = prod;
			ALU_RIP:   sum_wide = {{XLEN{1'b0}}, next_rip};
			default:   sum_wide = {{XLEN{1'b0}}, oprd2};
		endcase
	end

	// Result holds under back-pressure and clears on a bubble.
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else if (advance) begin
			result <= sum_wide;
		end else if (idle) begin
			result <= '0;
		end
	end

endmodule

/* verification/exec_sva.sv */
`timescale 1ns/1ns

module exec_sva
	import exec_pkg::*;
(
	input logic              clk,
	input logic              rst,
	input logic              enable,
	input logic              mem_blocked,
	input opcode_u           opcode,
	input logic [XLEN-1:0]   oprd1,
	input logic [XLEN-1:0]   oprd2,
	input logic [XLEN-1:0]   next_rip,
	input logic [2*XLEN-1:0] result,
	input logic [XLEN-1:0]   rflags,
	input logic              exe_mem,
	input logic              illegal,
	input logic              branch,
	input logic [XLEN-1:0]   branch_rip
);
	typedef enum logic [3:0] {
		K_ADD, K_OR, K_XOR, K_AND, K_MOV, K_MUL, K_JCC, K_JMP, K_CALL, K_RET, K_ILL
	} kind_e;

	kind_e             k;
	logic [XLEN-1:0]   sum;
	logic [XLEN:0]     sum_s;     // Sign-extended sum.
	logic [2*XLEN-1:0] prod;
	logic [7:0]        base;
	logic [2*XLEN-1:0] res_now;
	logic [XLEN-1:0]   flags_now;
	logic [2*XLEN-1:0] exp_res;
	logic [XLEN-1:0]   exp_flags; // Shadow RFLAGS.
	logic [XLEN-1:0]   exp_tgt;
	logic [2:0]        exp_ctl;   // exe_mem, illegal, branch.
	logic              failed = 1'b0;

	// Opcodes driven by the testbench.
	function automatic kind_e kind_of(input logic [9:0] op);
		casez (op)
			10'h001, 10'h303: return K_ADD;
			10'h009, 10'h301: return K_OR;
			10'h031, 10'h304: return K_XOR;
			10'h021, 10'h302: return K_AND;
			10'h089, 10'h08B, 10'h0B8, 10'h0C7: return K_MOV;
			10'h0F7:          return K_MUL;
			10'b00_0111_????, 10'b01_1000_????: return K_JCC;
			10'h0EB:          return K_JMP;
			10'h310:          return K_CALL;
			10'h0C3:          return K_RET;
			default:          return K_ILL;
		endcase
	endfunction

	assign k     = kind_of(opcode);
	assign sum   = oprd1 + oprd2;
	assign sum_s = {oprd1[XLEN-1], oprd1} + {oprd2[XLEN-1], oprd2};
	assign prod  = $signed({{XLEN{oprd1[XLEN-1]}}, oprd1}) *
		$signed({{XLEN{oprd2[XLEN-1]}}, oprd2});

	// Base x86 conditions indexed by cc[3:1].
	assign base = {
		exp_flags[RF_ZF] | (exp_flags[RF_SF] ^ exp_flags[RF_OF]),
		exp_flags[RF_SF] ^ exp_flags[RF_OF], exp_flags[RF_PF], exp_flags[RF_SF],
		exp_flags[RF_CF] | exp_flags[RF_ZF], exp_flags[RF_ZF], exp_flags[RF_CF],
		exp_flags[RF_OF]
	};

	always_comb begin
		res_now   = {{XLEN{1'b0}}, oprd2};
		flags_now = exp_flags;
		case (k)
			K_ADD:   res_now[XLEN-1:0] = sum;
			K_OR:    res_now[XLEN-1:0] = oprd1 | oprd2;
			K_XOR:   res_now[XLEN-1:0] = oprd1 ^ oprd2;
			K_AND:   res_now[XLEN-1:0] = oprd1 & oprd2;
			K_MUL:   res_now = prod;
			K_CALL:  res_now[XLEN-1:0] = next_rip;
			K_RET:   res_now[XLEN-1:0] = oprd1;
			default: ;
		endcase
		if (k inside {K_ADD, K_OR, K_XOR, K_AND, K_MUL}) begin
			flags_now[RF_ZF] = (res_now[XLEN-1:0] == '0);
			flags_now[RF_SF] = res_now[XLEN-1];
			flags_now[RF_PF] = ~^res_now[7:0];
			flags_now[RF_CF] = 1'b0; // Logic ops clear both.
			flags_now[RF_OF] = 1'b0;
		end
		if (k == K_ADD) begin
			flags_now[RF_CF] = (sum < oprd1); // Unsigned wrap.
			flags_now[RF_OF] = sum_s[XLEN] ^ sum_s[XLEN-1]; // Signed sum does not fit.
		end
		if (k == K_MUL) begin
			flags_now[RF_CF] = ($signed(prod) != $signed(prod[XLEN-1:0]));
			flags_now[RF_OF] = flags_now[RF_CF];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exp_res   <= '0;
			exp_flags <= '0;
			exp_ctl   <= '0;
			exp_tgt   <= '0;
		end else if (enable && !mem_blocked) begin
			exp_res    <= res_now;
			exp_flags  <= flags_now;
			exp_ctl[2] <= 1'b1;
			exp_ctl[1] <= (k == K_ILL);
			exp_ctl[0] <= (k == K_JCC) ? (base[opcode.cond.cc[3:1]] ^ opcode.cond.cc[0]) :
				(k inside {K_JMP, K_CALL, K_RET}); // Odd codes invert.
			exp_tgt    <= (k inside {K_CALL, K_RET}) ? oprd1 : next_rip + oprd1;
		end else if (!enable && !mem_blocked) begin
			exp_res <= '0;
			exp_ctl <= '0;
		end
	end

	a_result: assert property (@(posedge clk) disable iff (rst) result == exp_res)
		else begin
			$error("Fail result exp %h got %h", $sampled(exp_res), $sampled(result));
			failed = 1'b1;
		end

	a_rflags: assert property (@(posedge clk) disable iff (rst) rflags == exp_flags)
		else begin
			$error("Fail rflags exp %h got %h", $sampled(exp_flags), $sampled(rflags));
			failed = 1'b1;
		end

	a_ctl: assert property (@(posedge clk) disable iff (rst)
		{exe_mem, illegal, branch} == exp_ctl)
		else begin
			$error("Fail exe_mem/illegal/branch exp %h got %h", $sampled(exp_ctl),
				$sampled({exe_mem, illegal, branch}));
			failed = 1'b1;
		end

	a_target: assert property (@(posedge clk) disable iff (rst)
		exp_ctl[0] |-> branch_rip == exp_tgt)
		else begin
			$error("Fail branch_rip exp %h got %h", $sampled(exp_tgt), $sampled(branch_rip));
			failed = 1'b1;
		end

	a_hold: assert property (@(posedge clk) disable iff (rst)
		$past(mem_blocked) |-> $stable({result, rflags, exe_mem, illegal, branch, branch_rip}))
		else begin
			$error("Outputs changed while mem_blocked was high");
			failed = 1'b1;
		end

endmodule

bind exec_stage exec_sva exec_sva_inst (.*);

/* verification/exec_tb.sv */
`timescale 1ns/1ns

module exec_tb
	import exec_pkg::*;
();
	logic              clk;
	logic              rst;
	logic              enable;
	logic              mem_blocked;
	opcode_u           opcode;
	logic [XLEN-1:0]   oprd1;
	logic [XLEN-1:0]   oprd2;
	logic [XLEN-1:0]   oprd3;
	logic [XLEN-1:0]   next_rip;
	logic [2*XLEN-1:0] result;
	logic [XLEN-1:0]   rflags;
	logic              exe_mem;
	logic              illegal;
	logic              branch;
	logic [XLEN-1:0]   branch_rip;
	integer            seed = 32'h64ea;
	logic [XLEN-1:0]   r;
	// ALU, move, illegal and jump opcodes.
	logic [9:0]        ops [17] = '{10'h001, 10'h009, 10'h031, 10'h021, 10'h303, 10'h301,
		10'h302, 10'h304, 10'h089, 10'h08B, 10'h0B8, 10'h0C7, 10'h0F7, 10'h105, 10'h0EB,
		10'h310, 10'h0C3};

	tb_clock tb_clock_inst (.clk);

	exec_stage exec_stage_inst (.*);

	always @(posedge exec_stage_inst.exec_sva_inst.failed) begin
		$display("sim failed");
		$fatal(1, "Assertion failure in the bound checker");
	end

	function automatic logic [XLEN-1:0] rnd();
		return {$random(seed), $random(seed)};
	endfunction

	// Presents one instruction on a falling edge and waits for it to complete.
	task automatic run_op(input logic [9:0] op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b, input int hold, input logic bubble);
		int waited;
		enable      = 1'b1;
		opcode      = op;
		oprd1       = a;
		oprd2       = b;
		oprd3       = rnd();
		next_rip    = rnd();
		mem_blocked = (hold > 0);
		repeat (hold) @(negedge clk);
		mem_blocked = 1'b0;
		waited      = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!exe_mem && waited < 20);
		if (!exe_mem) begin
			$display("Timed out waiting for exe_mem");
			$display("sim failed");
			$fatal(1);
		end
		if (bubble) begin
			enable = 1'b0; // One idle cycle.
			@(negedge clk);
		end
	endtask

	initial begin
		rst         = 1'b1;
		enable      = 1'b0;
		mem_blocked = 1'b0;
		opcode      = '0;
		oprd1       = '0;
		oprd2       = '0;
		oprd3       = '0;
		next_rip    = '0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		repeat (3) foreach (ops[i]) run_op(ops[i], rnd(), rnd(), 0, 1);
		run_op(10'h0F7, 64'd7, 64'hFFFF_FFFF_FFFF_FFFD, 0, 1); // Small signed product.
		// Back-pressure over live outputs, then over a bubble.
		run_op(10'h001, rnd(), rnd(), 0, 0);
		run_op(10'h0F7, rnd(), rnd(), 3, 0);
		run_op(10'h310, rnd(), rnd(), 2, 1);
		run_op(10'h0C3, rnd(), rnd(), 4, 1);
		// Flag setups so each Jcc code is seen taken and not taken.
		for (int s = 0; s < 6; s++) begin
			r = rnd();
			case (s)
				0: run_op(10'h001, r, -r, 0, 1); // ZF and CF.
				1: run_op(10'h001, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 0, 1);
				2: run_op(10'h001, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0, 1);
				3: run_op(10'h009, 64'd1, 64'd0, 0, 1); // Odd parity, rest clear.
				4: run_op(10'h0F7, r, r, 0, 1);
				default: run_op(10'h021, r, ~r, 0, 1);
			endcase
			for (int c = 0; c < 16; c++) begin
				run_op({6'h07, c[3:0]}, rnd(), rnd(), 0, 0);
				run_op({6'h18, c[3:0]}, rnd(), rnd(), 0, 1);
			end
		end
		if (exec_stage_inst.exec_sva_inst.failed) begin
			$display("sim failed");
			$fatal(1);
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);
	initial clk = 1'b0;

	always #2 clk = ~clk; // 4 ns period.

endmodule
